// File: bomber_macros.svh
// Arena geometry, stat caps, start values and timer length, included by the RTL and testbench.
`ifndef BOMBER_MACROS_SVH
`define BOMBER_MACROS_SVH

`define ARENA_X0 9'd72		// pixel origin of the arena.
`define ARENA_Y0 9'd32
`define TILE_PX 16			// tile edge in pixels.
`define MAP_COLS 11
`define MAP_ROWS 11
`define MAP_AW 7			// map word address width.

`define X_MIN 9'd72			// position bounds, top left of sprite.
`define X_MAX 9'd232
`define Y_MIN 9'd32
`define Y_MAX 9'd192

`define P1_X0 9'd72
`define P2_X0 9'd232
`define P_Y0 9'd112

`define LIVES_START 2'd3
`define LIVES_CAP 2'd3
`define SPEED_START 4'd4	// pixels per frame.
`define SPEED_CAP 4'd8
`define STAT_CAP 2'd2		// cap of each 2 bit stat field.

// invincibility in clock cycles after a hit.
`define INV_CYCLES 200

`endif

// File: bomber_pkg.sv
// Tile codes, map word layout and player stat fields shared by the player datapath and its testbench.
`default_nettype none

package bomber_pkg;

	typedef enum logic [3:0]
	{
		TILE_EMPTY      = 4'd0,
		TILE_WALL       = 4'd1,
		TILE_BRICK      = 4'd2,
		TILE_EXTRA_BOMB = 4'd3,
		TILE_RADIUS     = 4'd4,
		TILE_POTENCY    = 4'd5,
		TILE_THROW      = 4'd6,
		TILE_LIFE       = 4'd7,
		TILE_SPEED      = 4'd8,
		TILE_HP_ICON    = 4'd9,
		TILE_BOMB       = 4'd10,
		TILE_EXPLOSION  = 4'd11,
		TILE_P1         = 4'd12,
		TILE_P2         = 4'd13,
		TILE_P1_INV     = 4'd14,
		TILE_P2_INV     = 4'd15
	} tile_code_e;

	// one word of the tile map.
	typedef struct packed
	{
		logic       explosion;	// tile is inside a blast.
		logic [2:0] spare;
		tile_code_e code;
	} map_word_t;

	typedef struct packed
	{
		logic [1:0] bombs;		// extra bombs, 0 means one.
		logic [1:0] radius;
		logic [1:0] potency;
	} player_stats_t;

endpackage

`default_nettype wire

// File: probe_if.sv
// Corner probe handshake between the frame sequencer and one player unit, one instance per player.
`timescale 1ns/10ps
`default_nettype none
`include "bomber_macros.svh"

interface probe_if
	import bomber_pkg::*;
();
	logic              check;	// tile word valid for one cycle.
	logic [1:0]        corner;	// bit 0 right side, bit 1 bottom side.
	map_word_t         tile;
	logic              start;	// latch move inputs.
	logic              step;	// apply move and hit.
	logic [`MAP_AW-1:0] adr;
	logic              pickup;

	modport sequencer
	(
		output check, corner, tile, start, step,
		input  adr, pickup
	);

	modport player
	(
		input  check, corner, tile, start, step,
		output adr, pickup
	);

endinterface

`default_nettype wire

// File: coordinate_counter.sv
// Bounded sprite coordinate, stepped by the player speed toward larger or smaller values.
`timescale 1ns/10ps
`default_nettype none

module coordinate_counter
(
	input  wire logic       clock,
	input  wire logic       reset,
	input  wire logic [8:0] start_coord,
	input  wire logic [8:0] min_coord,
	input  wire logic [8:0] max_coord,
	input  wire logic [3:0] increment,
	input  wire logic       enable,
	input  wire logic       direction,	// high counts up.
	output logic [8:0]      coord
);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			coord <= start_coord;
		else if (enable)
		begin
			if (direction)
			begin
				if ({1'b0, coord} + increment <= {1'b0, max_coord})
					coord <= coord + increment;
			end
			else if ({1'b0, coord} >= {1'b0, min_coord} + increment)
				coord <= coord - increment;	// otherwise hold at the edge.
		end
	end

endmodule

`default_nettype wire

// File: invincibility_timer.sv
// Down-counter holding a player invincible for a fixed number of cycles after a hit.
`timescale 1ns/10ps
`default_nettype none
`include "bomber_macros.svh"

module invincibility_timer
#(
	parameter int CYCLES = `INV_CYCLES
)
(
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic start,
	output logic      active
);

	localparam int CW = $clog2(CYCLES + 1);

	logic [CW-1:0] count;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			count <= '0;
		else if (start)
			count <= CW'(CYCLES);
		else if (count != '0)
			count <= count - 1'b1;
	end

	assign active = (count != '0);

endmodule

`default_nettype wire

// File: frame_sequencer.sv
// Frame FSM that walks the eight corner probes and runs the Wishbone map reads and clearing writes.
`timescale 1ns/10ps
`default_nettype none
`include "bomber_macros.svh"

module frame_sequencer
	import bomber_pkg::*;
(
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire logic               tick,
	output logic                    busy,
	output logic                    frame_done,
	output logic                    wb_cyc,
	output logic                    wb_stb,
	output logic                    wb_we,
	output logic [`MAP_AW-1:0]      wb_adr,
	output logic [7:0]              wb_dat_w,
	input  wire logic [7:0]         wb_dat_r,
	input  wire logic               wb_ack,
	probe_if.sequencer              p1,
	probe_if.sequencer              p2
);

	typedef enum logic [1:0]
	{
		S_IDLE,
		S_READ,
		S_WRITE,
		S_STEP
	} state_e;

	localparam map_word_t EMPTY_WORD = '{explosion: 1'b0, spare: 3'b000, code: TILE_EMPTY};

	state_e             state;
	logic [2:0]         probe_cnt;	// msb picks the player, low bits the corner.
	logic               cyc_q;
	logic               we_q;
	logic               check_q;
	map_word_t          tile_q;
	logic [`MAP_AW-1:0] adr_q;		// address held for the clearing write.
	logic [`MAP_AW-1:0] sel_adr;
	logic               sel_pickup;
	logic               last_probe;
	logic               read_ack;

	assign sel_adr    = probe_cnt[2] ? p2.adr : p1.adr;
	assign sel_pickup = probe_cnt[2] ? p2.pickup : p1.pickup;
	assign last_probe = (probe_cnt == 3'd7);
	assign read_ack   = (state == S_READ) && cyc_q && wb_ack;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state      <= S_IDLE;
			probe_cnt  <= 3'd0;
			cyc_q      <= 1'b0;
			we_q       <= 1'b0;
			check_q    <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			check_q    <= 1'b0;
			frame_done <= 1'b0;
			case (state)
				S_IDLE:
				begin
					if (tick)
					begin
						state     <= S_READ;
						probe_cnt <= 3'd0;
						cyc_q     <= 1'b1;
					end
				end
				S_READ:
				begin
					if (cyc_q)
					begin
						if (wb_ack)
						begin
							cyc_q   <= 1'b0;
							check_q <= 1'b1;
						end
					end
					else if (check_q)
					begin
						if (sel_pickup)
						begin
							state <= S_WRITE;	// clear the power-up tile.
							cyc_q <= 1'b1;
							we_q  <= 1'b1;
						end
						else if (last_probe)
							state <= S_STEP;
						else
						begin
							probe_cnt <= probe_cnt + 3'd1;
							cyc_q     <= 1'b1;
						end
					end
					else
						cyc_q <= 1'b1;	// next read after a write.
				end
				S_WRITE:
				begin
					if (wb_ack)
					begin
						cyc_q <= 1'b0;
						we_q  <= 1'b0;
						if (last_probe)
							state <= S_STEP;
						else
						begin
							probe_cnt <= probe_cnt + 3'd1;
							state     <= S_READ;
						end
					end
				end
				default:
				begin
					state      <= S_IDLE;
					frame_done <= 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (read_ack)
		begin
			tile_q <= map_word_t'(wb_dat_r);
			adr_q  <= sel_adr;
		end
	end

	assign busy     = (state != S_IDLE);
	assign wb_cyc   = cyc_q;
	assign wb_stb   = cyc_q;
	assign wb_we    = we_q;
	assign wb_adr   = we_q ? adr_q : sel_adr;
	assign wb_dat_w = EMPTY_WORD;

	assign p1.check  = check_q & ~probe_cnt[2];
	assign p2.check  = check_q & probe_cnt[2];
	assign p1.corner = probe_cnt[1:0];
	assign p2.corner = probe_cnt[1:0];
	assign p1.tile   = tile_q;
	assign p2.tile   = tile_q;
	assign p1.start  = (state == S_IDLE) && tick;
	assign p2.start  = (state == S_IDLE) && tick;
	assign p1.step   = (state == S_STEP);
	assign p2.step   = (state == S_STEP);

endmodule

`default_nettype wire

// File: player_unit.sv
// One player's datapath: position, corner passability, lives, speed, stats and probe addressing.
`timescale 1ns/10ps
`default_nettype none
`include "bomber_macros.svh"

module player_unit
	import bomber_pkg::*;
(
	input  wire logic       clock,
	input  wire logic       reset,
	input  wire logic [8:0] start_x,
	input  wire logic       xmov,
	input  wire logic       xdir,
	input  wire logic       ymov,
	input  wire logic       ydir,
	probe_if.player         probe,
	output logic [8:0]      x,
	output logic [8:0]      y,
	output logic [1:0]      lives,
	output player_stats_t   stats,
	output logic [3:0]      speed,
	output logic            invincible
);

	logic       xmov_q, xdir_q, ymov_q, ydir_q;
	logic [3:0] passable;	// one bit per corner.
	logic       hit_q;
	logic       tile_passable;
	logic       x_enable, y_enable;
	logic       take_hit;
	logic [8:0] corner_x, corner_y;
	logic [8:0] probe_x, probe_y;
	logic [3:0] col, row;

	// map pixel to tile index, clamped into the arena.
	function automatic logic [3:0] tile_index(input logic [8:0] pix, input logic [8:0] origin,
		input int count);
		logic [8:0] offset;
		offset = pix - origin;
		if (pix < origin)
			return 4'd0;
		else if (offset / `TILE_PX > count - 1)
			return 4'(count - 1);
		else
			return 4'(offset / `TILE_PX);
	endfunction

	always_comb
	begin
		corner_x = probe.corner[0] ? x + 9'd15 : x;
		corner_y = probe.corner[1] ? y + 9'd15 : y;
		probe_x  = corner_x;
		probe_y  = corner_y;
		if (xmov_q)
			probe_x = xdir_q ? corner_x + speed : corner_x - speed;	// look one step ahead.
		if (ymov_q)
			probe_y = ydir_q ? corner_y + speed : corner_y - speed;
		col = tile_index(probe_x, `ARENA_X0, `MAP_COLS);
		row = tile_index(probe_y, `ARENA_Y0, `MAP_ROWS);
	end

	assign probe.adr    = `MAP_AW'(row * `MAP_COLS + col);
	assign probe.pickup = probe.tile.code inside {[TILE_EXTRA_BOMB:TILE_SPEED]};
	assign tile_passable = probe.tile.code inside
		{TILE_EMPTY, [TILE_EXTRA_BOMB:TILE_SPEED], [TILE_P1:TILE_P2_INV]};

	// both corners on the leading side must be free.
	assign x_enable = probe.step & xmov_q & (xdir_q ? (passable[1] & passable[3])
		: (passable[0] & passable[2]));
	assign y_enable = probe.step & ymov_q & (ydir_q ? (passable[2] & passable[3])
		: (passable[0] & passable[1]));
	assign take_hit = probe.step & hit_q & ~invincible;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			xmov_q   <= 1'b0;
			xdir_q   <= 1'b0;
			ymov_q   <= 1'b0;
			ydir_q   <= 1'b0;
			passable <= 4'b0000;
			hit_q    <= 1'b0;
			lives    <= `LIVES_START;
			speed    <= `SPEED_START;
			stats    <= '0;
		end
		else
		begin
			if (probe.start)
			begin
				xmov_q <= xmov;
				xdir_q <= xdir;
				ymov_q <= ymov;
				ydir_q <= ydir;
				hit_q  <= 1'b0;
			end
			if (probe.check)
			begin
				passable[probe.corner] <= tile_passable;
				if (probe.tile.explosion)
					hit_q <= 1'b1;
				case (probe.tile.code)
					TILE_EXTRA_BOMB:
						if (stats.bombs < `STAT_CAP)
							stats.bombs <= stats.bombs + 2'd1;
					TILE_RADIUS:
						if (stats.radius < `STAT_CAP)
							stats.radius <= stats.radius + 2'd1;
					TILE_POTENCY:
						if (stats.potency < `STAT_CAP)
							stats.potency <= stats.potency + 2'd1;
					TILE_LIFE:
						if (lives < `LIVES_CAP)
							lives <= lives + 2'd1;
					TILE_SPEED:
						if (speed < `SPEED_CAP)
							speed <= speed + 4'd1;
					default:
						;	// throw power-up is taken without effect.
				endcase
			end
			if (take_hit)
				lives <= (lives == 2'd0) ? 2'd0 : lives - 2'd1;
		end
	end

	coordinate_counter x_counter
	(
		.clock       (clock),
		.reset       (reset),
		.start_coord (start_x),
		.min_coord   (`X_MIN),
		.max_coord   (`X_MAX),
		.increment   (speed),
		.enable      (x_enable),
		.direction   (xdir_q),
		.coord       (x)
	);

	coordinate_counter y_counter
	(
		.clock       (clock),
		.reset       (reset),
		.start_coord (`P_Y0),
		.min_coord   (`Y_MIN),
		.max_coord   (`Y_MAX),
		.increment   (speed),
		.enable      (y_enable),
		.direction   (ydir_q),
		.coord       (y)
	);

	invincibility_timer #(.CYCLES(`INV_CYCLES)) inv_timer
	(
		.clock  (clock),
		.reset  (reset),
		.start  (take_hit),
		.active (invincible)
	);

endmodule

`default_nettype wire

// File: bomber_player_core.sv
// Player side of the bomberman datapath, probing the tile map over a Wishbone master once per tick.
`timescale 1ns/10ps
`default_nettype none
`include "bomber_macros.svh"

module bomber_player_core
	import bomber_pkg::*;
(
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire logic               tick,
	input  wire logic               p1_xmov,
	input  wire logic               p1_xdir,
	input  wire logic               p1_ymov,
	input  wire logic               p1_ydir,
	input  wire logic               p2_xmov,
	input  wire logic               p2_xdir,
	input  wire logic               p2_ymov,
	input  wire logic               p2_ydir,
	output logic                    wb_cyc,
	output logic                    wb_stb,
	output logic                    wb_we,
	output logic [`MAP_AW-1:0]      wb_adr,
	output logic [7:0]              wb_dat_w,
	input  wire logic [7:0]         wb_dat_r,
	input  wire logic               wb_ack,
	output logic [8:0]              p1_x,
	output logic [8:0]              p1_y,
	output logic [8:0]              p2_x,
	output logic [8:0]              p2_y,
	output logic [1:0]              p1_lives,
	output logic [1:0]              p2_lives,
	output player_stats_t           p1_stats,
	output player_stats_t           p2_stats,
	output logic [3:0]              p1_speed,
	output logic [3:0]              p2_speed,
	output logic                    p1_invincible,
	output logic                    p2_invincible,
	output logic                    busy,
	output logic                    frame_done
);

	probe_if p1_probe ();
	probe_if p2_probe ();

	frame_sequencer sequencer
	(
		.clock      (clock),
		.reset      (reset),
		.tick       (tick),
		.busy       (busy),
		.frame_done (frame_done),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.p1         (p1_probe.sequencer),
		.p2         (p2_probe.sequencer)
	);

	player_unit player_1
	(
		.clock      (clock),
		.reset      (reset),
		.start_x    (`P1_X0),
		.xmov       (p1_xmov),
		.xdir       (p1_xdir),
		.ymov       (p1_ymov),
		.ydir       (p1_ydir),
		.probe      (p1_probe.player),
		.x          (p1_x),
		.y          (p1_y),
		.lives      (p1_lives),
		.stats      (p1_stats),
		.speed      (p1_speed),
		.invincible (p1_invincible)
	);

	player_unit player_2
	(
		.clock      (clock),
		.reset      (reset),
		.start_x    (`P2_X0),
		.xmov       (p2_xmov),
		.xdir       (p2_xdir),
		.ymov       (p2_ymov),
		.ydir       (p2_ydir),
		.probe      (p2_probe.player),
		.x          (p2_x),
		.y          (p2_y),
		.lives      (p2_lives),
		.stats      (p2_stats),
		.speed      (p2_speed),
		.invincible (p2_invincible)
	);

endmodule

`default_nettype wire

// File: tb_map_model.sv
// Wishbone classic slave holding the tile map for the testbench, with a random ack delay per access.
`timescale 1ns/10ps
`default_nettype none
`include "bomber_macros.svh"

module tb_map_model
(
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire logic               cyc,
	input  wire logic               stb,
	input  wire logic               we,
	input  wire logic [`MAP_AW-1:0] adr,
	input  wire logic [7:0]         dat_w,
	output logic [7:0]              dat_r,
	output logic                    ack
);

	integer             seed = 81775;
	logic [7:0]         mem [0:`MAP_COLS*`MAP_ROWS-1];	// preset by the testbench.
	int                 delay;			// wait cycles before the next ack.
	int                 write_count;

	always @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			ack         <= 1'b0;
			dat_r       <= 8'h00;
			write_count <= 0;
			delay       <= $unsigned($random(seed)) % 4;
		end
		else
		begin
			ack <= 1'b0;
			if (cyc && stb && !ack)
			begin
				if (delay == 0)
				begin
					ack <= 1'b1;
					if (we)
					begin
						mem[adr]    <= dat_w;
						write_count <= write_count + 1;
					end
					else
						dat_r <= mem[adr];
					delay <= $unsigned($random(seed)) % 4;
				end
				else
					delay <= delay - 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_bomber.sv
// Testbench for the player core: drives frames against a map model and checks against a reference.
`timescale 1ns/10ps
`default_nettype none
`include "bomber_macros.svh"

module tb_bomber
	import bomber_pkg::*;
();

	logic               clock = 1'b0;
	logic               reset;
	logic               tick;
	logic               p1_xmov, p1_xdir, p1_ymov, p1_ydir;
	logic               p2_xmov, p2_xdir, p2_ymov, p2_ydir;
	logic               wb_cyc, wb_stb, wb_we, wb_ack;
	logic [`MAP_AW-1:0] wb_adr;
	logic [7:0]         wb_dat_w, wb_dat_r;
	logic [8:0]         p1_x, p1_y, p2_x, p2_y;
	logic [1:0]         p1_lives, p2_lives;
	player_stats_t      p1_stats, p2_stats;
	logic [3:0]         p1_speed, p2_speed;
	logic               p1_invincible, p2_invincible;
	logic               busy, frame_done;

	// reference state, index 0 is player 1.
	int         rx [2];
	int         ry [2];
	int         rspd [2];
	int         rlives [2];
	int         rstat [2][3];	// bombs, radius, potency.
	int         last_hit [2];	// cycle of the last hit.
	logic [3:0] mv [2];			// xmov, xdir, ymov, ydir.
	logic [7:0] shadow [0:120];
	int         exp_writes;

	always #2 clock = ~clock;

	bomber_player_core dut0
	(
		.clock (clock), .reset (reset), .tick (tick),
		.p1_xmov (p1_xmov), .p1_xdir (p1_xdir), .p1_ymov (p1_ymov), .p1_ydir (p1_ydir),
		.p2_xmov (p2_xmov), .p2_xdir (p2_xdir), .p2_ymov (p2_ymov), .p2_ydir (p2_ydir),
		.wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
		.wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
		.p1_x (p1_x), .p1_y (p1_y), .p2_x (p2_x), .p2_y (p2_y),
		.p1_lives (p1_lives), .p2_lives (p2_lives), .p1_stats (p1_stats), .p2_stats (p2_stats),
		.p1_speed (p1_speed), .p2_speed (p2_speed),
		.p1_invincible (p1_invincible), .p2_invincible (p2_invincible),
		.busy (busy), .frame_done (frame_done)
	);

	tb_map_model map0
	(
		.clock (clock), .reset (reset), .cyc (wb_cyc), .stb (wb_stb), .we (wb_we),
		.adr (wb_adr), .dat_w (wb_dat_w), .dat_r (wb_dat_r), .ack (wb_ack)
	);

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("test failed");
		$fatal(1, "simulation stopped");
	endtask

	assert property (@(posedge clock) disable iff (reset) wb_stb == wb_cyc)
		else stop_run($sformatf("Fail at %0t: wb_stb differs from wb_cyc", $time));
	assert property (@(posedge clock) disable iff (reset)
		wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr) && $stable(wb_we))
		else stop_run($sformatf("Fail at %0t: bus cycle changed before ack", $time));
	assert property (@(posedge clock) disable iff (reset) wb_cyc && wb_ack |=> !wb_cyc)
		else stop_run($sformatf("Fail at %0t: wb_cyc held after ack", $time));
	assert property (@(posedge clock) disable iff (reset) wb_cyc && wb_we |-> wb_dat_w == 8'h00)
		else stop_run($sformatf("Fail at %0t: clearing write not empty", $time));

	function automatic int pixel_to_tile(input int pix, input int origin);
		if (pix < origin)
			return 0;
		else if ((pix - origin) / `TILE_PX > 10)
			return 10;
		else
			return (pix - origin) / `TILE_PX;
	endfunction

	function automatic int step_coord(input int v, input logic dir, input int lo, input int hi,
		input int inc);
		if (dir)
			return (v + inc <= hi) ? v + inc : v;
		else
			return (v >= lo + inc) ? v - inc : v;
	endfunction

	task automatic set_tile(input int a, input logic [7:0] w);
		map0.mem[a] = w;
		shadow[a]   = w;
	endtask

	task automatic fill_map(input logic [7:0] w);
		for (int a = 0; a < 121; a++)
			set_tile(a, w);
	endtask

	// probes, pickups, moves and hits of one frame; upd is the cycle of the update edge.
	task automatic predict_frame(input int upd);
		int px, py, a, code;
		logic [3:0] pass;
		logic hit;
		for (int p = 0; p < 2; p++)
		begin
			pass = 4'b0000;
			hit  = 1'b0;
			for (int c = 0; c < 4; c++)
			begin
				px = rx[p] + ((c % 2) ? 15 : 0);
				py = ry[p] + ((c / 2) ? 15 : 0);
				if (mv[p][3])
					px = mv[p][2] ? px + rspd[p] : px - rspd[p];
				if (mv[p][1])
					py = mv[p][0] ? py + rspd[p] : py - rspd[p];
				a = pixel_to_tile(py, 32) * 11 + pixel_to_tile(px, 72);
				code = shadow[a][3:0];
				pass[c] = (code == 0) || (code >= 3 && code <= 8) || (code >= 12);
				if (shadow[a][7])
					hit = 1'b1;
				if (code >= 3 && code <= 5 && rstat[p][code-3] < 2)
					rstat[p][code-3]++;
				if (code == 7 && rlives[p] < 3)
					rlives[p]++;
				if (code == 8 && rspd[p] < 8)
					rspd[p]++;
				if (code >= 3 && code <= 8)
				begin
					shadow[a] = 8'h00;	// power-up tile is cleared.
					exp_writes++;
				end
			end
			if (mv[p][3] && (mv[p][2] ? (pass[1] && pass[3]) : (pass[0] && pass[2])))
				rx[p] = step_coord(rx[p], mv[p][2], 72, 232, rspd[p]);
			if (mv[p][1] && (mv[p][0] ? (pass[2] && pass[3]) : (pass[0] && pass[1])))
				ry[p] = step_coord(ry[p], mv[p][0], 32, 192, rspd[p]);
			if (hit && (upd - last_hit[p] > `INV_CYCLES))
			begin
				rlives[p] = (rlives[p] == 0) ? 0 : rlives[p] - 1;
				last_hit[p] = upd;
			end
		end
	endtask

	task automatic check_player(input int p, input int upd, input logic [8:0] x, input logic [8:0] y,
		input logic [1:0] lives, input player_stats_t st, input logic [3:0] spd, input logic inv);
		logic exp_inv;
		exp_inv = (upd - last_hit[p] < `INV_CYCLES);
		assert (x == rx[p] && y == ry[p])
			else stop_run($sformatf("Fail at %0t: player %0d at (%0d,%0d), expected (%0d,%0d)",
				$time, p + 1, x, y, rx[p], ry[p]));
		assert (lives == rlives[p] && spd == rspd[p] && inv == exp_inv)
			else stop_run($sformatf("Fail at %0t: player %0d lives %0d speed %0d inv %0d",
				$time, p + 1, lives, spd, inv));
		assert (st.bombs == rstat[p][0] && st.radius == rstat[p][1] && st.potency == rstat[p][2])
			else stop_run($sformatf("Fail at %0t: player %0d stats %b", $time, p + 1, st));
	endtask

	task automatic run_frame(input logic [3:0] m1, input logic [3:0] m2, input bit extra_tick);
		int n;
		int upd;
		mv[0] = m1;
		mv[1] = m2;
		@(posedge clock);
		{p1_xmov, p1_xdir, p1_ymov, p1_ydir} <= m1;
		{p2_xmov, p2_xdir, p2_ymov, p2_ydir} <= m2;
		tick <= 1'b1;
		@(posedge clock);
		tick <= 1'b0;
		n = 0;
		while (frame_done !== 1'b1)
		begin
			@(posedge clock);
			n++;
			if (extra_tick && n == 3)
				tick <= 1'b1;	// must be ignored while busy.
			if (n == 4)
				tick <= 1'b0;
			if (n > 150)
				stop_run("timeout while waiting for frame_done");
		end
		upd = $time / 4 - 1;
		predict_frame(upd);
		check_player(0, upd, p1_x, p1_y, p1_lives, p1_stats, p1_speed, p1_invincible);
		check_player(1, upd, p2_x, p2_y, p2_lives, p2_stats, p2_speed, p2_invincible);
		for (int a = 0; a < 121; a++)
			assert (map0.mem[a] == shadow[a])
				else stop_run($sformatf("Fail at %0t: map word %0d is %h, expected %h",
					$time, a, map0.mem[a], shadow[a]));
		assert (map0.write_count == exp_writes)
			else stop_run($sformatf("Fail at %0t: %0d clearing writes, expected %0d",
				$time, map0.write_count, exp_writes));
		if (extra_tick)
			repeat (8)
			begin
				@(posedge clock);
				assert (!busy && !frame_done)
					else stop_run($sformatf("Fail at %0t: extra frame after busy tick", $time));
			end
	endtask

	initial
	begin
		int n;
		reset = 1'b1;
		tick  = 1'b0;
		{p1_xmov, p1_xdir, p1_ymov, p1_ydir} = 4'b0000;
		{p2_xmov, p2_xdir, p2_ymov, p2_ydir} = 4'b0000;
		rx = '{72, 232};
		ry = '{112, 112};
		rspd = '{4, 4};
		rlives = '{3, 3};
		rstat = '{'{0, 0, 0}, '{0, 0, 0}};
		last_hit = '{-1000, -1000};
		exp_writes = 0;
		fill_map(8'h00);
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		assert (!busy && !frame_done && !wb_cyc && !wb_stb && !wb_we)
			else stop_run($sformatf("Fail at %0t: control outputs high after reset", $time));
		check_player(0, 0, p1_x, p1_y, p1_lives, p1_stats, p1_speed, p1_invincible);
		check_player(1, 0, p2_x, p2_y, p2_lives, p2_stats, p2_speed, p2_invincible);

		// free movement into the corners, then clamped.
		for (int f = 0; f < 45; f++)
			run_frame(4'b1110, 4'b1011, f == 10);

		// walls and a brick in the way.
		set_tile(8, 8'h01);
		set_tile(19, 8'h01);
		set_tile(112, 8'h02);
		for (int f = 0; f < 8; f++)
			run_frame(4'b1000, 4'b1100, 1'b0);
		for (int f = 0; f < 6; f++)
			run_frame(4'b0011, 4'b0010, 1'b0);
		for (int f = 0; f < 6; f++)
			run_frame(4'b1011, 4'b1110, 1'b0);

		// explosions under both players.
		fill_map(8'h80);
		run_frame(4'b0000, 4'b0000, 1'b0);
		run_frame(4'b0000, 4'b0000, 1'b0);
		n = 0;
		while (p1_invincible || p2_invincible)
		begin
			@(posedge clock);
			n++;
			if (n > `INV_CYCLES + 20)
				stop_run("timeout while waiting for invincibility to end");
		end
		repeat (5) @(posedge clock);
		run_frame(4'b0000, 4'b0000, 1'b0);
		run_frame(4'b0000, 4'b0000, 1'b1);

		// power-ups everywhere, throw included.
		for (int a = 0; a < 121; a++)
			set_tile(a, 8'(3 + (a % 6)));
		for (int f = 0; f < 6; f++)
			run_frame(4'b1001, 4'b1111, 1'b0);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
bomber_pkg.sv
probe_if.sv
coordinate_counter.sv
invincibility_timer.sv
frame_sequencer.sv
player_unit.sv
bomber_player_core.sv
tb_map_model.sv
tb_bomber.sv
